//--- bench/tb_sha_hub.sv
`timescale 1ns/10ps
`default_nettype none
`include "sha_hub_macros.svh"

module tb_sha_hub;

  // rough bus op count incl. status polls
  localparam int BUS_OPS         = 200;
  localparam int WATCHDOG_CYCLES = 20 * (BUS_OPS + 2 * `SHA_ROUNDS);
  localparam int POLL_LIMIT      = 40;  // status reads per hash

  // fips 180-4 reference digests, H0 first
  localparam logic [0:7][31:0] DIGEST_ABC = {
    32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
    32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
  };
  localparam logic [0:7][31:0] DIGEST_448 = {
    32'h248d6a61, 32'hd20638b8, 32'he5c02693, 32'h0c3e6039,
    32'ha33ce459, 32'h64ff2167, 32'hf6ecedd4, 32'h19db06c1
  };

  logic                  clk_100mhz;
  logic                  rstn_i;
  sha_hub_pkg::sys_req_t sys_req;
  sha_hub_pkg::sys_rsp_t sys_rsp;
  logic                  activated;
  int                    value_errs;  // wrong read values
  int                    bus_errs;    // handshake violations
  logic [31:0]           msg_words[$];  // padded message
  logic [31:0]           rd;
  logic [31:0]           ctrl_val;

  sha_hub_top sha_hub_top_i (
    .clk_100mhz  (clk_100mhz),
    .rstn_i      (rstn_i),
    .sys_req_i   (sys_req),
    .sys_rsp_o   (sys_rsp),
    .activated_o (activated)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;  // 100 mhz
  end

  // ------------------------------
  // bus protocol checks
  // ------------------------------
  ack_follows_req: assert property (@(posedge clk_100mhz) disable iff (!rstn_i)
      sys_rsp.ack == $past(sys_req.wen | sys_req.ren))
    else begin
      bus_errs++;
      $display("ERR %0t: ack not exactly one cycle after request", $time);
    end

  err_stays_low: assert property (@(posedge clk_100mhz) disable iff (!rstn_i)
      !sys_rsp.err)
    else begin
      bus_errs++;
      $display("ERR %0t: err high on response", $time);
    end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_100mhz);
    $display("timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp)
      else begin
        value_errs++;
        $display("ERR %0t: %s got %08h expected %08h", $time, what, got, exp);
      end
  endtask

  task automatic idle_gap;
    repeat ($urandom % 3) @(posedge clk_100mhz);  // 0 to 2 idle cycles
  endtask

  task automatic bus_write(input logic [19:0] ofs, input logic [31:0] data);
    idle_gap();
    @(posedge clk_100mhz);
    sys_req.addr  <= {12'h000, ofs};
    sys_req.wdata <= data;
    sys_req.sel   <= 4'hf;
    sys_req.wen   <= 1'b1;
    @(posedge clk_100mhz);
    sys_req.wen <= 1'b0;  // single cycle pulse
    @(negedge clk_100mhz);
    assert (sys_rsp.ack)
      else begin
        bus_errs++;
        $display("ERR %0t: write to %05h not acked", $time, ofs);
      end
  endtask

  task automatic bus_read(input logic [19:0] ofs, output logic [31:0] data);
    idle_gap();
    @(posedge clk_100mhz);
    sys_req.addr <= {12'h000, ofs};
    sys_req.ren  <= 1'b1;
    @(posedge clk_100mhz);
    sys_req.ren <= 1'b0;
    @(negedge clk_100mhz);  // ack and rdata settled here
    assert (sys_rsp.ack)
      else begin
        bus_errs++;
        $display("ERR %0t: read of %05h not acked", $time, ofs);
      end
    data = sys_rsp.rdata;
  endtask

  // fips padding: 0x80, zeros, 64-bit big endian bit length
  task automatic pad_message(input string msg);
    int          len;
    int          total;
    logic [63:0] bitlen;
    logic [7:0]  b;
    logic [31:0] w;
    msg_words.delete();
    len    = msg.len();
    total  = ((len + 8) / 64 + 1) * 64;
    bitlen = 64'(len) * 8;
    w      = '0;
    for (int i = 0; i < total; i++) begin
      if (i < len)             b = msg[i];
      else if (i == len)       b = 8'h80;
      else if (i >= total - 8) b = bitlen[8*(total-1-i) +: 8];
      else                     b = 8'h00;
      w = {w[23:0], b};
      if (i % 4 == 3) msg_words.push_back(w);  // big endian words
    end
  endtask

  task automatic push_range(input int lo, input int hi);
    for (int i = lo; i < hi; i++) bus_write(`SHA_OFS_PUSH, msg_words[i]);
  endtask

  task automatic push_random(input int n);
    for (int i = 0; i < n; i++) bus_write(`SHA_OFS_PUSH, $urandom);  // filler
  endtask

  task automatic wait_hash;
    logic [31:0] st;
    int          polls;
    st    = '0;
    polls = 0;
    while (!st[1] && polls < POLL_LIMIT) begin
      bus_read(`SHA_OFS_SHA_STATUS, st);
      polls++;
    end
    assert (st[1])
      else begin
        value_errs++;
        $display("hash_valid still low after %0d status reads", polls);
      end
  endtask

  // 0x12c holds word 0, 0x110 word 7
  task automatic check_digest(input logic [0:7][31:0] exp, input string name);
    logic [31:0] w;
    for (int i = 0; i < 8; i++) begin
      bus_read(`SHA_OFS_HASH_BASE + 20'(28 - 4 * i), w);
      check_eq(w, exp[i], $sformatf("%s digest word %0d", name, i));
    end
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    void'($urandom(32'h6b5e));
    $timeformat(-9, 1, " ns", 0);
    value_errs = 0;
    bus_errs   = 0;
    sys_req    <= '0;
    rstn_i     <= 1'b0;
    repeat (5) @(posedge clk_100mhz);
    rstn_i <= 1'b1;
    @(negedge clk_100mhz);
    assert (!sys_rsp.ack)
      else begin
        bus_errs++;
        $display("ERR %0t: ack high after reset", $time);
      end

    // register access
    bus_read(`SHA_OFS_VERSION, rd);
    check_eq(rd, `SHA_VERSION, "version");
    ctrl_val = $urandom & ~32'h1;  // enable stays off
    bus_write(`SHA_OFS_CTRL, ctrl_val);
    bus_read(`SHA_OFS_CTRL, rd);
    check_eq(rd, ctrl_val, "ctrl readback");
    check_eq(32'(activated), 32'd0, "activated_o while disabled");
    bus_read(20'h00050, rd);
    check_eq(rd, 32'd0, "unmapped read");
    bus_write(`SHA_OFS_CTRL, 32'h1);
    check_eq(32'(activated), 32'd1, "activated_o after enable");
    bus_read(`SHA_OFS_STATUS, rd);
    check_eq(rd, 32'h11, "global status");

    // one-shot flags: reset, start, finalize
    for (int f = 0; f < 3; f++) begin
      bus_write(`SHA_OFS_SHA_CTRL, 32'(1 << f));
      bus_read(`SHA_OFS_SHA_CTRL, rd);
      check_eq(rd & 32'h7, 32'h0, $sformatf("sha ctrl flag %0d cleared", f));
    end

    // single block, "abc"
    bus_write(`SHA_OFS_SHA_CTRL, 32'h1);
    pad_message("abc");
    push_range(0, 16);
    bus_read(`SHA_OFS_SHA_STATUS, rd);
    check_eq(rd & 32'h10, 32'h0, "empty after one block");
    bus_write(`SHA_OFS_SHA_CTRL, 32'h2);
    wait_hash();
    check_digest(DIGEST_ABC, "abc");

    // two chained blocks, no reset between them
    bus_write(`SHA_OFS_SHA_CTRL, 32'h1);
    pad_message("abcdbcdecdefdefgefghfghighijhijkijkljklmklmnlmnomnopnopq");
    push_range(0, 32);
    bus_write(`SHA_OFS_SHA_CTRL, 32'h2);
    wait_hash();
    bus_write(`SHA_OFS_SHA_CTRL, 32'h2);
    wait_hash();
    check_digest(DIGEST_448, "448-bit");

    // fifo flags, bits 6..4 are full, almost_full, empty
    bus_write(`SHA_OFS_SHA_CTRL, 32'h1);
    push_random(30);  // 15 entries
    bus_read(`SHA_OFS_SHA_STATUS, rd);
    check_eq(rd & 32'h70, 32'h20, "flags at 15 entries");
    push_random(2);
    bus_read(`SHA_OFS_SHA_STATUS, rd);
    check_eq(rd & 32'h70, 32'h40, "flags at 16 entries");
    push_random(2);  // dropped
    bus_read(`SHA_OFS_SHA_STATUS, rd);
    check_eq(rd & 32'h70, 32'h40, "flags after push while full");
    bus_write(`SHA_OFS_SHA_CTRL, 32'h1);
    bus_read(`SHA_OFS_SHA_STATUS, rd);
    check_eq(rd & 32'h70, 32'h10, "flags after reset");

    $display("error counts: value %0d, bus %0d", value_errs, bus_errs);
    if (value_errs == 0 && bus_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+logic
logic/sha_hub_pkg.sv
logic/sha_bus_regs.sv
logic/sha_block_fifo.sv
logic/sha256_core.sv
logic/sha_hub_top.sv
bench/tb_sha_hub.sv

//--- logic/sha256_core.sv
`timescale 1ns/10ps
`default_nettype none
`include "sha_hub_macros.svh"

module sha256_core (
  input  logic                 clk_100mhz,
  input  logic                 rstn_i,
  input  logic                 en_i,          // low reloads IV
  input  logic                 start_i,
  input  logic [511:0]         block_i,       // word i at bits 32i
  output logic                 ready_o,
  output logic                 hash_valid_o,
  output sha_hub_pkg::digest_t digest_o
);

  localparam int RND_W = $clog2(`SHA_ROUNDS);
  localparam logic [RND_W-1:0] RND_LAST = RND_W'(`SHA_ROUNDS - 1);

  // fips 180-4 initial hash, H7 down to H0
  localparam sha_hub_pkg::digest_t H_INIT = {
    32'h5be0cd19, 32'h1f83d9ab, 32'h9b05688c, 32'h510e527f,
    32'ha54ff53a, 32'h3c6ef372, 32'hbb67ae85, 32'h6a09e667
  };

  // round constants, K[0] first
  localparam logic [0:63][31:0] K = {
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
    32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
    32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
    32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
    32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
    32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  typedef enum logic [1:0] {
    ST_IDLE,  // waiting for start
    ST_RUN,   // one round per cycle
    ST_ADD    // fold into H
  } state_t;

  // ------------------------------
  // sigma functions
  // ------------------------------
  function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  function automatic logic [31:0] big_s0(input logic [31:0] x);
    return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
  endfunction

  function automatic logic [31:0] big_s1(input logic [31:0] x);
    return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
  endfunction

  function automatic logic [31:0] small_s0(input logic [31:0] x);
    return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
  endfunction

  function automatic logic [31:0] small_s1(input logic [31:0] x);
    return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
  endfunction

  state_t               state_r;
  logic [RND_W-1:0]     rnd_r;
  logic                 hash_valid_r;
  sha_hub_pkg::digest_t h_r;       // chaining state
  logic [15:0][31:0]    w_r;       // w_r[0] is W[t]
  logic [31:0]          a_r, b_r, c_r, d_r, e_r, f_r, g_r, hh_r;
  logic [31:0]          w_next;
  logic [31:0]          t1;
  logic [31:0]          t2;

  // W[t+16] from W[t+14], W[t+9], W[t+1], W[t]
  assign w_next = small_s1(w_r[14]) + w_r[9] + small_s0(w_r[1]) + w_r[0];

  assign t1 = hh_r + big_s1(e_r) + ((e_r & f_r) ^ (~e_r & g_r)) + K[rnd_r] + w_r[0];
  assign t2 = big_s0(a_r) + ((a_r & b_r) ^ (a_r & c_r) ^ (b_r & c_r));  // maj

  // ------------------------------
  // control and chaining
  // ------------------------------
  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i || !en_i) begin
      state_r      <= ST_IDLE;
      rnd_r        <= '0;
      hash_valid_r <= 1'b0;
      h_r          <= H_INIT;
    end else begin
      case (state_r)
        ST_IDLE: begin
          if (start_i) begin
            state_r      <= ST_RUN;
            rnd_r        <= '0;
            hash_valid_r <= 1'b0;  // old digest no longer current
          end
        end
        ST_RUN: begin
          rnd_r <= rnd_r + 1'b1;
          if (rnd_r == RND_LAST) state_r <= ST_ADD;
        end
        ST_ADD: begin
          h_r[0] <= h_r[0] + a_r;
          h_r[1] <= h_r[1] + b_r;
          h_r[2] <= h_r[2] + c_r;
          h_r[3] <= h_r[3] + d_r;
          h_r[4] <= h_r[4] + e_r;
          h_r[5] <= h_r[5] + f_r;
          h_r[6] <= h_r[6] + g_r;
          h_r[7] <= h_r[7] + hh_r;
          hash_valid_r <= 1'b1;
          state_r      <= ST_IDLE;
        end
        default: state_r <= ST_IDLE;
      endcase
    end
  end

  // ------------------------------
  // working variables and schedule
  // ------------------------------
  always_ff @(posedge clk_100mhz) begin
    if (state_r == ST_IDLE && start_i) begin
      w_r  <= block_i;  // latch block, W[0..15]
      a_r  <= h_r[0];
      b_r  <= h_r[1];
      c_r  <= h_r[2];
      d_r  <= h_r[3];
      e_r  <= h_r[4];
      f_r  <= h_r[5];
      g_r  <= h_r[6];
      hh_r <= h_r[7];
    end else if (state_r == ST_RUN) begin
      w_r  <= {w_next, w_r[15:1]};  // shift toward w_r[0]
      hh_r <= g_r;
      g_r  <= f_r;
      f_r  <= e_r;
      e_r  <= d_r + t1;
      d_r  <= c_r;
      c_r  <= b_r;
      b_r  <= a_r;
      a_r  <= t1 + t2;
    end
  end

  assign ready_o      = (state_r == ST_IDLE);
  assign hash_valid_o = hash_valid_r;
  assign digest_o     = h_r;

endmodule

`default_nettype wire

//--- logic/sha_block_fifo.sv
`timescale 1ns/10ps
`default_nettype none
`include "sha_hub_macros.svh"

module sha_block_fifo (
  input  logic                     clk_100mhz,
  input  logic                     rstn_i,
  input  logic                     clear_i,      // sync flush
  input  logic [63:0]              push_data_i,
  input  logic                     push_wr_i,
  input  logic                     block_rd_i,   // drops 8 entries
  output logic [511:0]             block_o,
  output sha_hub_pkg::fifo_flags_t flags_o
);

  localparam int DEPTH = `SHA_FIFO_BLOCKS * 8;
  localparam int PTR_W = $clog2(DEPTH);

  localparam logic [PTR_W:0] CNT_FULL  = (PTR_W+1)'(DEPTH);
  localparam logic [PTR_W:0] CNT_AFULL = (PTR_W+1)'(DEPTH - 1);  // one slot free
  localparam logic [PTR_W:0] CNT_BLOCK = (PTR_W+1)'(8);

  logic [63:0]      mem_r [DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [PTR_W:0]   count_r;  // entries stored
  logic             wr_ok;
  logic             rd_ok;

  assign wr_ok = push_wr_i && (count_r != CNT_FULL);  // drop when full
  assign rd_ok = block_rd_i && (count_r >= CNT_BLOCK);

  // ------------------------------
  // pointers and count
  // ------------------------------
  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i || clear_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (wr_ok) wr_ptr_r <= wr_ptr_r + 1'b1;
      if (rd_ok) rd_ptr_r <= rd_ptr_r + PTR_W'(8);  // whole block
      count_r <= count_r + {{PTR_W{1'b0}}, wr_ok} - (rd_ok ? CNT_BLOCK : '0);
    end
  end

  // storage
  always_ff @(posedge clk_100mhz) begin
    if (wr_ok) mem_r[wr_ptr_r] <= push_data_i;
  end

  // oldest 8 entries, entry j carries words 2j and 2j+1
  always_comb begin
    logic [PTR_W-1:0] idx;
    idx = '0;
    for (int j = 0; j < 8; j++) begin
      idx = rd_ptr_r + PTR_W'(j);  // wraps in the ring
      block_o[64*j +: 64] = mem_r[idx];
    end
  end

  // ------------------------------
  // flags
  // ------------------------------
  assign flags_o.full        = (count_r == CNT_FULL);
  assign flags_o.almost_full = (count_r == CNT_AFULL);
  assign flags_o.empty       = (count_r < CNT_BLOCK);  // partial block does not count

endmodule

`default_nettype wire

//--- logic/sha_bus_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "sha_hub_macros.svh"

module sha_bus_regs (
  input  logic                     clk_100mhz,
  input  logic                     rstn_i,
  input  sha_hub_pkg::sys_req_t    sys_req_i,
  output sha_hub_pkg::sys_rsp_t    sys_rsp_o,
  output logic                     activated_o,
  output logic                     sha_en_o,
  output logic [63:0]              push_data_o,
  output logic                     push_wr_o,
  output logic                     block_rd_o,
  input  sha_hub_pkg::fifo_flags_t fifo_flags_i,
  input  logic                     ready_i,
  input  logic                     hash_valid_i,
  input  sha_hub_pkg::digest_t     digest_i
);

  // byte lane merge for writable registers
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_v,
                                              input logic [31:0] new_v,
                                              input logic [3:0]  sel);
    logic [31:0] res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) res[8*b +: 8] = new_v[8*b +: 8];
    end
    return res;
  endfunction

  logic [31:0]             ctrl_r;       // global control
  sha_hub_pkg::sha_ctrl_t  sha_ctrl_r;   // flags live for one cycle
  sha_hub_pkg::sha_ctrl_t  sha_ctrl_wr;  // merged write value
  logic                    sha_en;
  logic [19:0]             ofs;
  logic                    push_wen;
  logic                    push_hi_r;    // next push fills the high half
  logic [63:0]             push_data_r;
  logic                    push_wr_r;
  logic                    flush_w;
  logic                    hash_valid_d;
  sha_hub_pkg::digest_t    hash_r;
  logic [19:0]             hash_ofs;
  logic                    hash_hit;
  logic [31:0]             status_w;
  sha_hub_pkg::sha_status_t sha_status_w;
  logic [31:0]             rd_mux;
  sha_hub_pkg::sys_rsp_t   rsp_r;

  assign ofs         = sys_req_i.addr[19:0];
  assign push_wen    = sys_req_i.wen && (ofs == `SHA_OFS_PUSH);
  assign sha_ctrl_wr = merge_bytes(sha_ctrl_r, sys_req_i.wdata, sys_req_i.sel);
  assign sha_en      = ctrl_r[sha_hub_pkg::CTRL_ENABLE_BIT] & ~sha_ctrl_r.reset;
  assign flush_w     = sha_ctrl_r.finalize & push_hi_r;  // odd word count left over

  // ------------------------------
  // register writes
  // ------------------------------
  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      ctrl_r     <= '0;
      sha_ctrl_r <= '0;
      push_hi_r  <= 1'b0;
      push_wr_r  <= 1'b0;
    end else begin
      sha_ctrl_r.reset    <= 1'b0;  // one-shot flags
      sha_ctrl_r.start    <= 1'b0;
      sha_ctrl_r.finalize <= 1'b0;
      push_wr_r           <= 1'b0;
      if (flush_w) begin
        push_wr_r <= 1'b1;  // entry goes out with zero upper word
        push_hi_r <= 1'b0;
      end
      if (sys_req_i.wen) begin
        case (ofs)
          `SHA_OFS_CTRL: ctrl_r <= merge_bytes(ctrl_r, sys_req_i.wdata, sys_req_i.sel);
          `SHA_OFS_SHA_CTRL: begin
            sha_ctrl_r <= sha_ctrl_wr;
            if (sha_ctrl_wr.reset || sha_ctrl_wr.start) push_hi_r <= 1'b0;
          end
          `SHA_OFS_PUSH: begin
            push_hi_r <= ~push_hi_r;
            push_wr_r <= push_hi_r;  // pair complete
          end
          default: ;  // unmapped, ignored
        endcase
      end
    end
  end

  // word pairing data, low half first
  always_ff @(posedge clk_100mhz) begin
    if (flush_w) push_data_r[63:32] <= '0;
    if (push_wen && !push_hi_r) push_data_r[31:0] <= sys_req_i.wdata;
    if (push_wen && push_hi_r) push_data_r[63:32] <= sys_req_i.wdata;
  end

  // ------------------------------
  // digest capture on rising hash_valid
  // ------------------------------
  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i || !sha_en) hash_valid_d <= 1'b0;
    else                    hash_valid_d <= hash_valid_i;
  end

  always_ff @(posedge clk_100mhz) begin
    if (hash_valid_i && !hash_valid_d) hash_r <= digest_i;
  end

  // ------------------------------
  // read back
  // ------------------------------
  assign hash_ofs = ofs - `SHA_OFS_HASH_BASE;  // wraps high below the base
  assign hash_hit = (hash_ofs[19:5] == '0) && (hash_ofs[1:0] == 2'b00);

  always_comb begin
    status_w = '0;
    status_w[sha_hub_pkg::STAT_ACTIVATED_BIT] = ctrl_r[sha_hub_pkg::CTRL_ENABLE_BIT];
    status_w[sha_hub_pkg::STAT_SHA_EN_BIT]    = sha_en;
  end

  always_comb begin
    sha_status_w             = '0;
    sha_status_w.full        = fifo_flags_i.full;
    sha_status_w.almost_full = fifo_flags_i.almost_full;
    sha_status_w.empty       = fifo_flags_i.empty;
    sha_status_w.hash_valid  = hash_valid_i;
    sha_status_w.ready       = ready_i;
  end

  always_comb begin
    rd_mux = '0;
    case (ofs)
      `SHA_OFS_CTRL:       rd_mux = ctrl_r;
      `SHA_OFS_STATUS:     rd_mux = status_w;
      `SHA_OFS_VERSION:    rd_mux = `SHA_VERSION;
      `SHA_OFS_SHA_CTRL:   rd_mux = sha_ctrl_r;
      `SHA_OFS_SHA_STATUS: rd_mux = sha_status_w;
      default: begin
        if (hash_hit) rd_mux = hash_r[3'd7 - hash_ofs[4:2]];  // 0x12c holds H0
      end
    endcase
  end

  always_ff @(posedge clk_100mhz) begin
    if (!rstn_i) begin
      rsp_r <= '0;
    end else begin
      rsp_r.ack <= sys_req_i.wen | sys_req_i.ren;  // every access acked
      rsp_r.err <= 1'b0;
      if (sys_req_i.ren) rsp_r.rdata <= rd_mux;
    end
  end

  assign sys_rsp_o   = rsp_r;
  assign activated_o = ctrl_r[sha_hub_pkg::CTRL_ENABLE_BIT];
  assign sha_en_o    = sha_en;
  assign push_data_o = push_data_r;
  assign push_wr_o   = push_wr_r;
  // pop only when the engine and a whole block are there
  assign block_rd_o  = sha_ctrl_r.start & ready_i & ~fifo_flags_i.empty & sha_en;

endmodule

`default_nettype wire

//--- logic/sha_hub_macros.svh
`ifndef SHA_HUB_MACROS_SVH
`define SHA_HUB_MACROS_SVH

// ------------------------------
// bus offsets, 20-bit decoded field
// ------------------------------
`define SHA_OFS_CTRL        20'h00000  // global control, enable in bit 0
`define SHA_OFS_STATUS      20'h00004  // global status
`define SHA_OFS_VERSION     20'h0000C  // version word, read only
`define SHA_OFS_SHA_CTRL    20'h00100  // sha-256 control flags
`define SHA_OFS_SHA_STATUS  20'h00104  // sha-256 status
`define SHA_OFS_PUSH        20'h0010C  // message word push, write only
`define SHA_OFS_HASH_BASE   20'h00110  // 8 digest words up to 0x12c

// version word, YYMMDDss layout
`define SHA_VERSION         32'h24060301

// ------------------------------
// sizes
// ------------------------------
// block fifo capacity in 512-bit blocks
// 8 entries of 64 bits per block, keep the product a power of two
`define SHA_FIFO_BLOCKS     2

// compression rounds per block
`define SHA_ROUNDS          64

`endif

//--- logic/sha_hub_pkg.sv
`default_nettype none

package sha_hub_pkg;

  // ------------------------------
  // bit positions
  // ------------------------------
  localparam int CTRL_ENABLE_BIT    = 0;  // global control register
  localparam int STAT_ACTIVATED_BIT = 0;  // global status register
  localparam int STAT_SHA_EN_BIT    = 4;

  // sha-256 control register, flags clear themselves
  typedef struct packed {
    logic [28:0] rsvd;
    logic        finalize;  // bit 2, flush a half filled entry
    logic        start;     // bit 1, pop one block into the engine
    logic        reset;     // bit 0, restart the hash chain
  } sha_ctrl_t;

  // sha-256 status register
  typedef struct packed {
    logic [24:0] rsvd_hi;
    logic        full;         // bit 6
    logic        almost_full;  // bit 5
    logic        empty;        // bit 4, no whole block stored
    logic [1:0]  rsvd_lo;
    logic        hash_valid;   // bit 1
    logic        ready;        // bit 0
  } sha_status_t;

  // ------------------------------
  // system bus
  // ------------------------------
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  sel;    // byte lanes
    logic        wen;    // one cycle pulse
    logic        ren;    // one cycle pulse
  } sys_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
    logic        ack;
  } sys_rsp_t;

  typedef struct packed {
    logic full;
    logic almost_full;
    logic empty;
  } fifo_flags_t;

  // word k is H_k, word 0 is the first digest word
  typedef logic [7:0][31:0] digest_t;

endpackage

`default_nettype wire

//--- logic/sha_hub_top.sv
`timescale 1ns/10ps
`default_nettype none

module sha_hub_top (
  input  logic                  clk_100mhz,
  input  logic                  rstn_i,
  input  sha_hub_pkg::sys_req_t sys_req_i,
  output sha_hub_pkg::sys_rsp_t sys_rsp_o,
  output logic                  activated_o
);

  // ------------------------------
  // internal wiring
  // ------------------------------
  logic                     sha_en;
  logic [63:0]              push_data;   // paired words
  logic                     push_wr;
  logic                     block_rd;    // gated start
  logic [511:0]             block;
  sha_hub_pkg::fifo_flags_t fifo_flags;
  logic                     ready;
  logic                     hash_valid;
  sha_hub_pkg::digest_t     digest;

  sha_bus_regs sha_bus_regs_i (
    .clk_100mhz   (clk_100mhz),
    .rstn_i       (rstn_i),
    .sys_req_i    (sys_req_i),
    .sys_rsp_o    (sys_rsp_o),
    .activated_o  (activated_o),
    .sha_en_o     (sha_en),
    .push_data_o  (push_data),
    .push_wr_o    (push_wr),
    .block_rd_o   (block_rd),
    .fifo_flags_i (fifo_flags),
    .ready_i      (ready),
    .hash_valid_i (hash_valid),
    .digest_i     (digest)
  );

  sha_block_fifo sha_block_fifo_i (
    .clk_100mhz  (clk_100mhz),
    .rstn_i      (rstn_i),
    .clear_i     (~sha_en),     // flush while disabled
    .push_data_i (push_data),
    .push_wr_i   (push_wr),
    .block_rd_i  (block_rd),
    .block_o     (block),
    .flags_o     (fifo_flags)
  );

  sha256_core sha256_core_i (
    .clk_100mhz   (clk_100mhz),
    .rstn_i       (rstn_i),
    .en_i         (sha_en),
    .start_i      (block_rd),
    .block_i      (block),
    .ready_o      (ready),
    .hash_valid_o (hash_valid),
    .digest_o     (digest)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build with verilator and run, pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_sha_hub -f compile.f -o tb_sha_hub_sim \
  && ./obj_dir/tb_sha_hub_sim | tee /dev/stderr | grep -x "Done: no errors" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
